/* src/exe_pkg.sv */
// shared op codes, encodings and widths for the execute stage
// only the opcode/funct pair is decoded, other fields of a word are don't care
// internal alu op codes are private to this design, not mips encodings

package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;  // register number
    localparam int alu_op_w   = 5;
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int imm_w      = 16;

    // internal alu operations
    localparam logic [alu_op_w-1:0] op_add  = 5'd0;   // traps on overflow
    localparam logic [alu_op_w-1:0] op_addu = 5'd1;
    localparam logic [alu_op_w-1:0] op_sub  = 5'd2;   // traps on overflow
    localparam logic [alu_op_w-1:0] op_subu = 5'd3;
    localparam logic [alu_op_w-1:0] op_and  = 5'd4;
    localparam logic [alu_op_w-1:0] op_or   = 5'd5;
    localparam logic [alu_op_w-1:0] op_xor  = 5'd6;
    localparam logic [alu_op_w-1:0] op_nor  = 5'd7;
    localparam logic [alu_op_w-1:0] op_slt  = 5'd8;
    localparam logic [alu_op_w-1:0] op_sltu = 5'd9;
    localparam logic [alu_op_w-1:0] op_sll  = 5'd10;  // also sllv
    localparam logic [alu_op_w-1:0] op_srl  = 5'd11;  // also srlv
    localparam logic [alu_op_w-1:0] op_sra  = 5'd12;  // also srav
    localparam logic [alu_op_w-1:0] op_clz  = 5'd13;
    localparam logic [alu_op_w-1:0] op_clo  = 5'd14;
    localparam logic [alu_op_w-1:0] op_lui  = 5'd15;

    // primary opcodes
    localparam logic [opcode_w-1:0] opc_special  = 6'h00;
    localparam logic [opcode_w-1:0] opc_special2 = 6'h1c;
    localparam logic [opcode_w-1:0] opc_addi     = 6'h08;
    localparam logic [opcode_w-1:0] opc_addiu    = 6'h09;
    localparam logic [opcode_w-1:0] opc_slti     = 6'h0a;
    localparam logic [opcode_w-1:0] opc_sltiu    = 6'h0b;
    localparam logic [opcode_w-1:0] opc_andi     = 6'h0c;
    localparam logic [opcode_w-1:0] opc_ori      = 6'h0d;
    localparam logic [opcode_w-1:0] opc_xori     = 6'h0e;
    localparam logic [opcode_w-1:0] opc_lui      = 6'h0f;

    // funct codes under special
    localparam logic [funct_w-1:0] fn_sll  = 6'h00;
    localparam logic [funct_w-1:0] fn_srl  = 6'h02;
    localparam logic [funct_w-1:0] fn_sra  = 6'h03;
    localparam logic [funct_w-1:0] fn_sllv = 6'h04;
    localparam logic [funct_w-1:0] fn_srlv = 6'h06;
    localparam logic [funct_w-1:0] fn_srav = 6'h07;
    localparam logic [funct_w-1:0] fn_add  = 6'h20;
    localparam logic [funct_w-1:0] fn_addu = 6'h21;
    localparam logic [funct_w-1:0] fn_sub  = 6'h22;
    localparam logic [funct_w-1:0] fn_subu = 6'h23;
    localparam logic [funct_w-1:0] fn_and  = 6'h24;
    localparam logic [funct_w-1:0] fn_or   = 6'h25;
    localparam logic [funct_w-1:0] fn_xor  = 6'h26;
    localparam logic [funct_w-1:0] fn_nor  = 6'h27;
    localparam logic [funct_w-1:0] fn_slt  = 6'h2a;
    localparam logic [funct_w-1:0] fn_sltu = 6'h2b;
    // funct codes under special2
    localparam logic [funct_w-1:0] fn_clz  = 6'h20;
    localparam logic [funct_w-1:0] fn_clo  = 6'h21;

    // one instruction word, register view and immediate view
    typedef union packed {
        struct packed {
            logic [opcode_w-1:0]   opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] shamt;
            logic [funct_w-1:0]    funct;
        } r;
        struct packed {
            logic [opcode_w-1:0]   opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [imm_w-1:0]      imm;
        } i;
    } instr_word_u;

endpackage

/* src/exe_ifs.sv */
// internal links of the execute stage, both use valid/ready
// a transfer happens on a rising edge with valid and ready both high

`timescale 1ns/1ps

// decode -> alu
interface alu_req_if;
    logic                         valid;
    logic                         ready;
    logic [exe_pkg::alu_op_w-1:0] op;
    logic [exe_pkg::xlen-1:0]     a;   // shift amount for shifts
    logic [exe_pkg::xlen-1:0]     b;
    logic [exe_pkg::reg_addr_w-1:0] dest;
    logic                         reserved;

    modport source (output valid, op, a, b, dest, reserved, input ready);
    modport sink   (input valid, op, a, b, dest, reserved, output ready);
endinterface

// alu -> result stage
interface alu_rsp_if;
    logic                           valid;
    logic                           ready;
    logic [exe_pkg::xlen-1:0]       result;
    logic                           overflow;
    logic [exe_pkg::reg_addr_w-1:0] dest;
    logic                           reserved;

    modport source (output valid, result, overflow, dest, reserved, input ready);
    modport sink   (input valid, result, overflow, dest, reserved, output ready);
endinterface

/* src/count_bits.sv */
// leading zero / leading one count of one word, result 0 to 32
// purely combinational, a long priority chain at 32 bits

`timescale 1ns/1ps

module count_bits (
    input  logic                     ones,   // 1 counts leading ones
    input  logic [exe_pkg::xlen-1:0] value,
    output logic [exe_pkg::xlen-1:0] count
);

    logic found;

    always_comb begin
        count = exe_pkg::xlen;  // every bit matched
        found = 1'b0;
        // scan from the msb, stop at the first bit that differs
        for (int i = exe_pkg::xlen - 1; i >= 0; i--) begin
            if (!found && (value[i] != ones)) begin
                count = exe_pkg::xlen - 1 - i;
                found = 1'b1;
            end
        end
    end

endmodule

/* src/exe_decode.sv */
// input side of the execute stage, decodes one word and holds it in the issue reg
// register values come from an earlier stage, no forwarding here
// unknown words go down as op add with reserved set

`timescale 1ns/1ps

module exe_decode (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  logic        valid,
    output logic        ready,
    alu_req_if.source   req
);

    exe_pkg::instr_word_u           iw;
    logic [exe_pkg::alu_op_w-1:0]   dec_op;
    logic [exe_pkg::xlen-1:0]       dec_a;
    logic [exe_pkg::xlen-1:0]       dec_b;
    logic [exe_pkg::reg_addr_w-1:0] dec_dest;
    logic                           dec_reserved;
    logic [exe_pkg::xlen-1:0]       imm_sext;
    logic [exe_pkg::xlen-1:0]       imm_zext;
    logic [exe_pkg::xlen-1:0]       shamt_zext;
    logic                           accept;

    assign iw = instr;

    assign imm_sext   = {{(exe_pkg::xlen-exe_pkg::imm_w){iw.i.imm[exe_pkg::imm_w-1]}}, iw.i.imm};
    assign imm_zext   = {{(exe_pkg::xlen-exe_pkg::imm_w){1'b0}}, iw.i.imm};
    assign shamt_zext = {{(exe_pkg::xlen-exe_pkg::reg_addr_w){1'b0}}, iw.r.shamt};

    always_comb begin
        // r-type defaults
        dec_op       = exe_pkg::op_add;
        dec_a        = rs_value;
        dec_b        = rt_value;
        dec_dest     = iw.r.rd;
        dec_reserved = 1'b0;
        case (iw.r.opcode)
            exe_pkg::opc_special: begin
                case (iw.r.funct)
                    exe_pkg::fn_add:  dec_op = exe_pkg::op_add;
                    exe_pkg::fn_addu: dec_op = exe_pkg::op_addu;
                    exe_pkg::fn_sub:  dec_op = exe_pkg::op_sub;
                    exe_pkg::fn_subu: dec_op = exe_pkg::op_subu;
                    exe_pkg::fn_and:  dec_op = exe_pkg::op_and;
                    exe_pkg::fn_or:   dec_op = exe_pkg::op_or;
                    exe_pkg::fn_xor:  dec_op = exe_pkg::op_xor;
                    exe_pkg::fn_nor:  dec_op = exe_pkg::op_nor;
                    exe_pkg::fn_slt:  dec_op = exe_pkg::op_slt;
                    exe_pkg::fn_sltu: dec_op = exe_pkg::op_sltu;
                    exe_pkg::fn_sll: begin
                        dec_op = exe_pkg::op_sll;
                        dec_a  = shamt_zext;
                    end
                    exe_pkg::fn_srl: begin
                        dec_op = exe_pkg::op_srl;
                        dec_a  = shamt_zext;
                    end
                    exe_pkg::fn_sra: begin
                        dec_op = exe_pkg::op_sra;
                        dec_a  = shamt_zext;
                    end
                    exe_pkg::fn_sllv: dec_op = exe_pkg::op_sll;  // amount from rs
                    exe_pkg::fn_srlv: dec_op = exe_pkg::op_srl;
                    exe_pkg::fn_srav: dec_op = exe_pkg::op_sra;
                    default:          dec_reserved = 1'b1;
                endcase
            end
            exe_pkg::opc_special2: begin
                case (iw.r.funct)
                    exe_pkg::fn_clz: dec_op = exe_pkg::op_clz;
                    exe_pkg::fn_clo: dec_op = exe_pkg::op_clo;
                    default:         dec_reserved = 1'b1;
                endcase
            end
            default: begin
                // immediate forms write rt
                dec_dest = iw.i.rt;
                dec_b    = imm_sext;
                case (iw.i.opcode)
                    exe_pkg::opc_addi:  dec_op = exe_pkg::op_add;
                    exe_pkg::opc_addiu: dec_op = exe_pkg::op_addu;
                    exe_pkg::opc_slti:  dec_op = exe_pkg::op_slt;
                    exe_pkg::opc_sltiu: dec_op = exe_pkg::op_sltu;  // sign-extended, compared unsigned
                    exe_pkg::opc_andi: begin
                        dec_op = exe_pkg::op_and;
                        dec_b  = imm_zext;
                    end
                    exe_pkg::opc_ori: begin
                        dec_op = exe_pkg::op_or;
                        dec_b  = imm_zext;
                    end
                    exe_pkg::opc_xori: begin
                        dec_op = exe_pkg::op_xor;
                        dec_b  = imm_zext;
                    end
                    exe_pkg::opc_lui: begin
                        dec_op = exe_pkg::op_lui;
                        dec_b  = imm_zext;  // alu moves it up
                    end
                    default: begin
                        dec_reserved = 1'b1;
                        dec_dest     = iw.r.rd;
                        dec_b        = rt_value;
                    end
                endcase
            end
        endcase
    end

    assign ready  = !req.valid || req.ready;  // empty or draining
    assign accept = valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else if (accept) begin
            req.valid <= 1'b1;
        end else if (req.ready) begin
            req.valid <= 1'b0;
        end
    end

    // issue register payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op       <= dec_op;
            req.a        <= dec_a;
            req.b        <= dec_b;
            req.dest     <= dec_dest;
            req.reserved <= dec_reserved;
        end
    end

endmodule

/* src/exe_alu.sv */
// combinational alu of the execute stage, no clock
// shifts take their amount from the low 5 bits of a and move b
// overflow only for the trapping add and sub

`timescale 1ns/1ps

module exe_alu (
    alu_req_if.sink   req,
    alu_rsp_if.source rsp
);

    localparam int msb = exe_pkg::xlen - 1;

    logic [exe_pkg::xlen-1:0] sum;
    logic [exe_pkg::xlen-1:0] diff;
    logic [exe_pkg::xlen-1:0] lead_count;
    logic [4:0]               shamt;
    logic                     ovf_add;
    logic                     ovf_sub;

    assign sum   = req.a + req.b;
    assign diff  = req.a - req.b;
    assign shamt = req.a[4:0];

    count_bits u_count_bits (
        .ones  (req.op == exe_pkg::op_clo),
        .value (req.a),
        .count (lead_count)
    );

    always_comb begin
        case (req.op)
            exe_pkg::op_add,
            exe_pkg::op_addu: rsp.result = sum;
            exe_pkg::op_sub,
            exe_pkg::op_subu: rsp.result = diff;
            exe_pkg::op_and:  rsp.result = req.a & req.b;
            exe_pkg::op_or:   rsp.result = req.a | req.b;
            exe_pkg::op_xor:  rsp.result = req.a ^ req.b;
            exe_pkg::op_nor:  rsp.result = ~(req.a | req.b);
            exe_pkg::op_slt: begin
                if ($signed(req.a) < $signed(req.b)) begin
                    rsp.result = 1;
                end else begin
                    rsp.result = '0;
                end
            end
            exe_pkg::op_sltu: begin
                if (req.a < req.b) begin
                    rsp.result = 1;
                end else begin
                    rsp.result = '0;
                end
            end
            exe_pkg::op_sll:  rsp.result = req.b << shamt;
            exe_pkg::op_srl:  rsp.result = req.b >> shamt;
            exe_pkg::op_sra:  rsp.result = $signed(req.b) >>> shamt;
            exe_pkg::op_clz,
            exe_pkg::op_clo:  rsp.result = lead_count;
            exe_pkg::op_lui:  rsp.result = req.b << 16;
            default:          rsp.result = '0;  // no such op from decode
        endcase
    end

    // same signs in, other sign out
    assign ovf_add = (req.a[msb] == req.b[msb]) && (sum[msb] != req.a[msb]);
    // signs differ and result lost the sign of a
    assign ovf_sub = (req.a[msb] != req.b[msb]) && (diff[msb] != req.a[msb]);

    assign rsp.overflow = ((req.op == exe_pkg::op_add) && ovf_add)
                       || ((req.op == exe_pkg::op_sub) && ovf_sub);

    assign rsp.dest     = req.dest;
    assign rsp.reserved = req.reserved;

    // handshake passes straight through
    assign rsp.valid = req.valid;
    assign req.ready = rsp.ready;

endmodule

/* src/exe_result.sv */
// output side of the execute stage, one result register
// write_en is formed from the held flags, qualify it with valid
// holds its contents while ready is low

`timescale 1ns/1ps

module exe_result (
    input  logic        clk,
    input  logic        reset,
    alu_rsp_if.sink     rsp,
    output logic [31:0] result,
    output logic [4:0]  dest,
    output logic        write_en,
    output logic        overflow,
    output logic        reserved,
    output logic        valid,
    input  logic        ready
);

    logic load;

    assign rsp.ready = !valid || ready;
    assign load      = rsp.valid && rsp.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;  // item left, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result   <= rsp.result;
            dest     <= rsp.dest;
            overflow <= rsp.overflow;
            reserved <= rsp.reserved;
        end
    end

    // r0 is never written
    assign write_en = !overflow && !reserved && (dest != '0);

endmodule

/* src/exe_unit.sv */
// top of the execute stage, two register stages with the alu between them
// in_ready depends combinationally on out_ready
// one item per cycle when out_ready stays high

`timescale 1ns/1ps

module exe_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_rs_value,
    input  logic [31:0] in_rt_value,
    input  logic        in_valid,
    output logic        in_ready,
    output logic [31:0] out_result,
    output logic [4:0]  out_dest,
    output logic        out_write_en,
    output logic        out_overflow,
    output logic        out_reserved,
    output logic        out_valid,
    input  logic        out_ready
);

    alu_req_if req_if ();
    alu_rsp_if rsp_if ();

    exe_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .instr    (in_instr),
        .rs_value (in_rs_value),
        .rt_value (in_rt_value),
        .valid    (in_valid),
        .ready    (in_ready),
        .req      (req_if.source)
    );

    exe_alu u_alu (
        .req (req_if.sink),
        .rsp (rsp_if.source)
    );

    exe_result u_result (
        .clk      (clk),
        .reset    (reset),
        .rsp      (rsp_if.sink),
        .result   (out_result),
        .dest     (out_dest),
        .write_en (out_write_en),
        .overflow (out_overflow),
        .reserved (out_reserved),
        .valid    (out_valid),
        .ready    (out_ready)
    );

endmodule

/* testbench/exe_unit_props.sv */
// handshake and flag rules of exe_unit, attached with bind from the testbench
// payload registers have no reset, so flag rules only apply while out_valid is high

`timescale 1ns/1ps

module exe_unit_props (
    input logic        clk,
    input logic        reset,
    input logic [31:0] in_instr,
    input logic [31:0] in_rs_value,
    input logic [31:0] in_rt_value,
    input logic        in_valid,
    input logic        in_ready,
    input logic [31:0] out_result,
    input logic [4:0]  out_dest,
    input logic        out_write_en,
    input logic        out_overflow,
    input logic        out_reserved,
    input logic        out_valid,
    input logic        out_ready
);

    int violations = 0;  // polled by the testbench

    // input side held while stalled
    assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_instr)
            && $stable(in_rs_value) && $stable(in_rt_value))
    else begin
        violations++;
        $error("input changed while stalled");
    end

    // output side held while stalled
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_dest)
            && $stable(out_overflow) && $stable(out_reserved))
    else begin
        violations++;
        $error("output changed while stalled");
    end

    assert property (@(posedge clk) reset |=> !out_valid)
    else begin
        violations++;
        $error("out_valid high after reset");
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !(out_write_en && (out_overflow || out_reserved)))
    else begin
        violations++;
        $error("write_en high with overflow or reserved");
    end

endmodule

/* testbench/exe_unit_tb.sv */
// random instruction stream into exe_unit, checked against a model of the op rules
// inputs change 1 ns after the rising edge, handshakes are sampled on the falling edge
// unknown words are expected to add rs and rt, with reserved set

`timescale 1ns/1ps

module exe_unit_tb;

    localparam int num_items   = 3000;
    localparam int cycle_limit = 20 * num_items;
    localparam logic [15:0] imm_pool [4] = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff};
    // opcode and funct of every supported encoding, funct unused for i-type
    localparam logic [11:0] encodings [26] = '{
        {exe_pkg::opc_special, exe_pkg::fn_add},  {exe_pkg::opc_special, exe_pkg::fn_addu},
        {exe_pkg::opc_special, exe_pkg::fn_sub},  {exe_pkg::opc_special, exe_pkg::fn_subu},
        {exe_pkg::opc_special, exe_pkg::fn_and},  {exe_pkg::opc_special, exe_pkg::fn_or},
        {exe_pkg::opc_special, exe_pkg::fn_xor},  {exe_pkg::opc_special, exe_pkg::fn_nor},
        {exe_pkg::opc_special, exe_pkg::fn_slt},  {exe_pkg::opc_special, exe_pkg::fn_sltu},
        {exe_pkg::opc_special, exe_pkg::fn_sll},  {exe_pkg::opc_special, exe_pkg::fn_srl},
        {exe_pkg::opc_special, exe_pkg::fn_sra},  {exe_pkg::opc_special, exe_pkg::fn_sllv},
        {exe_pkg::opc_special, exe_pkg::fn_srlv}, {exe_pkg::opc_special, exe_pkg::fn_srav},
        {exe_pkg::opc_special2, exe_pkg::fn_clz}, {exe_pkg::opc_special2, exe_pkg::fn_clo},
        {exe_pkg::opc_addi, 6'h00},  {exe_pkg::opc_addiu, 6'h00}, {exe_pkg::opc_slti, 6'h00},
        {exe_pkg::opc_sltiu, 6'h00}, {exe_pkg::opc_andi, 6'h00},  {exe_pkg::opc_ori, 6'h00},
        {exe_pkg::opc_xori, 6'h00},  {exe_pkg::opc_lui, 6'h00}
    };

    logic        clk;
    logic        reset;
    logic [31:0] in_instr;
    logic [31:0] in_rs_value;
    logic [31:0] in_rt_value;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] out_result;
    logic [4:0]  out_dest;
    logic        out_write_en;
    logic        out_overflow;
    logic        out_reserved;
    logic        out_valid;
    logic        out_ready;

    logic [exe_pkg::xlen-1:0]       exp_result [$];
    logic [exe_pkg::reg_addr_w-1:0] exp_dest [$];
    logic                           exp_ovf [$];
    logic                           exp_rsv [$];
    logic                           exp_wen [$];
    int sent = 0;
    int received = 0;
    int cycles = 0;

    exe_unit u_dut (.*);

    bind exe_unit exe_unit_props u_props (.*);

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_word(input string name, input logic [exe_pkg::xlen-1:0] got,
                              input logic [exe_pkg::xlen-1:0] expected);
        if (got !== expected) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input logic [exe_pkg::reg_addr_w-1:0] got,
                             input logic [exe_pkg::reg_addr_w-1:0] expected);
        if (got !== expected) begin
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    // true when the 32-bit signed result does not fit
    function automatic logic signed_overflow(input logic [31:0] x, input logic [31:0] y,
                                             input logic subtract);
        longint s;
        s = subtract ? longint'($signed(x)) - longint'($signed(y))
                     : longint'($signed(x)) + longint'($signed(y));
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    function automatic logic [31:0] leading_run(input logic [31:0] v, input logic bit_val);
        logic [31:0] n;
        n = 0;
        for (int i = 31; i >= 0; i--) begin
            if (v[i] == bit_val && n == 31 - i) n++;  // only while the run is unbroken
        end
        return n;
    endfunction

    function automatic logic [31:0] pick_value();
        case ($urandom_range(9))
            0: return 32'h0000_0000;
            1: return 32'hffff_ffff;
            2: return 32'h7fff_ffff;
            3: return 32'h8000_0000;
            4: return $urandom() >> $urandom_range(31);     // leading zeros
            5: return ~($urandom() >> $urandom_range(31));  // leading ones
            default: return $urandom();
        endcase
    endfunction

    function automatic logic [31:0] pick_instr();
        exe_pkg::instr_word_u w;
        logic [11:0] enc;
        w = $urandom();
        if ($urandom_range(99) >= 5) begin
            enc = encodings[$urandom_range(25)];
            w.r.opcode = enc[11:6];
            if (enc[11:6] == exe_pkg::opc_special || enc[11:6] == exe_pkg::opc_special2) begin
                w.r.funct = enc[5:0];
            end else if ($urandom_range(3) == 0) begin
                w.i.imm = imm_pool[$urandom_range(3)];
            end
        end
        return w;
    endfunction

    // reference model, queues the expected output item
    task automatic predict(input logic [31:0] word, input logic [31:0] rs_v,
                           input logic [31:0] rt_v);
        exe_pkg::instr_word_u w;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        ovf;
        logic        rsv;
        w   = word;
        sx  = {{16{w.i.imm[15]}}, w.i.imm};
        zx  = {16'h0000, w.i.imm};
        res = '0;
        dst = w.r.rd;
        ovf = 1'b0;
        rsv = 1'b0;
        case (w.r.opcode)
            exe_pkg::opc_special: begin
                case (w.r.funct)
                    exe_pkg::fn_add: begin
                        res = rs_v + rt_v;
                        ovf = signed_overflow(rs_v, rt_v, 1'b0);
                    end
                    exe_pkg::fn_addu: res = rs_v + rt_v;
                    exe_pkg::fn_sub: begin
                        res = rs_v - rt_v;
                        ovf = signed_overflow(rs_v, rt_v, 1'b1);
                    end
                    exe_pkg::fn_subu: res = rs_v - rt_v;
                    exe_pkg::fn_and:  res = rs_v & rt_v;
                    exe_pkg::fn_or:   res = rs_v | rt_v;
                    exe_pkg::fn_xor:  res = rs_v ^ rt_v;
                    exe_pkg::fn_nor:  res = ~(rs_v | rt_v);
                    exe_pkg::fn_slt:  res = {31'b0, $signed(rs_v) < $signed(rt_v)};
                    exe_pkg::fn_sltu: res = {31'b0, rs_v < rt_v};
                    exe_pkg::fn_sll:  res = rt_v << w.r.shamt;
                    exe_pkg::fn_srl:  res = rt_v >> w.r.shamt;
                    exe_pkg::fn_sra:  res = $signed(rt_v) >>> w.r.shamt;
                    exe_pkg::fn_sllv: res = rt_v << rs_v[4:0];
                    exe_pkg::fn_srlv: res = rt_v >> rs_v[4:0];
                    exe_pkg::fn_srav: res = $signed(rt_v) >>> rs_v[4:0];
                    default:          rsv = 1'b1;
                endcase
            end
            exe_pkg::opc_special2: begin
                case (w.r.funct)
                    exe_pkg::fn_clz: res = leading_run(rs_v, 1'b0);
                    exe_pkg::fn_clo: res = leading_run(rs_v, 1'b1);
                    default:         rsv = 1'b1;
                endcase
            end
            default: begin
                dst = w.i.rt;
                case (w.i.opcode)
                    exe_pkg::opc_addi: begin
                        res = rs_v + sx;
                        ovf = signed_overflow(rs_v, sx, 1'b0);
                    end
                    exe_pkg::opc_addiu: res = rs_v + sx;
                    exe_pkg::opc_slti:  res = {31'b0, $signed(rs_v) < $signed(sx)};
                    exe_pkg::opc_sltiu: res = {31'b0, rs_v < sx};
                    exe_pkg::opc_andi:  res = rs_v & zx;
                    exe_pkg::opc_ori:   res = rs_v | zx;
                    exe_pkg::opc_xori:  res = rs_v ^ zx;
                    exe_pkg::opc_lui:   res = {w.i.imm, 16'h0000};
                    default:            rsv = 1'b1;
                endcase
            end
        endcase
        if (rsv) begin
            // unknown words run as a plain add of rs and rt into rd
            res = rs_v + rt_v;
            ovf = signed_overflow(rs_v, rt_v, 1'b0);
            dst = w.r.rd;
        end
        exp_result.push_back(res);
        exp_dest.push_back(dst);
        exp_ovf.push_back(ovf);
        exp_rsv.push_back(rsv);
        exp_wen.push_back(!ovf && !rsv && (dst != 5'd0));
    endtask

    task automatic check_output();
        if (exp_result.size() == 0) begin
            $display("output transfer at t=%0t with no item expected", $time);
            stop_with_failure();
        end else begin
            check_word("out_result", out_result, exp_result.pop_front());
            check_reg("out_dest", out_dest, exp_dest.pop_front());
            check_flag("out_overflow", out_overflow, exp_ovf.pop_front());
            check_flag("out_reserved", out_reserved, exp_rsv.pop_front());
            check_flag("out_write_en", out_write_en, exp_wen.pop_front());
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d items out", cycles, received,
                     num_items);
            stop_with_failure();
        end
    end

    initial begin
        logic in_fire;
        logic out_fire;
        void'($urandom(32'h350b2940));
        clk         = 1'b0;
        reset       = 1'b1;
        in_instr    = '0;
        in_rs_value = '0;
        in_rt_value = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);  // both stages empty
        check_flag("out_valid", out_valid, 1'b0);
        while (received < num_items) begin
            @(negedge clk);
            if (u_dut.u_props.violations != 0) begin
                $display("a handshake assertion failed before t=%0t", $time);
                stop_with_failure();
            end
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;
            if (out_fire) begin
                check_output();  // older item leaves before the new one is queued
                received++;
            end
            if (in_fire) begin
                predict(in_instr, in_rs_value, in_rt_value);
                sent++;
            end
            @(posedge clk);
            #1;
            if (in_fire || !in_valid) begin
                in_valid = (sent < num_items) && ($urandom_range(99) < 70);
                if (in_valid) begin
                    in_instr    = pick_instr();
                    in_rs_value = pick_value();
                    in_rt_value = pick_value();
                end
            end
            out_ready = ($urandom_range(99) < 70);
        end
        if (exp_result.size() != 0) begin
            $display("%0d expected items never came out", exp_result.size());
            stop_with_failure();
        end else if (u_dut.u_props.violations != 0) begin
            $display("a handshake assertion failed on the last cycle");
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* exe_unit.f */
src/exe_pkg.sv
src/exe_ifs.sv
src/count_bits.sv
src/exe_decode.sv
src/exe_alu.sv
src/exe_result.sv
src/exe_unit.sv
testbench/exe_unit_props.sv
testbench/exe_unit_tb.sv
